// ==== Makefile ====
# Verilator build and run of the DPC testbench.
# Any variable below can be overridden on the make command line.
VERILATOR ?= verilator
TOP       ?= dpc_tb
FILELIST  ?= dpc_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests
FAIL_MSG  ?= FAIL: see errors above

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) bench/dpc_model.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/dpc_model.svh ====
// Reference model of the DPC rules, included inside the testbench module.
// Reads the frame and configuration variables of the testbench and pushes
// the expected output pixels and per-frame counts onto its queues.
`ifndef dpc_model_svh
`define dpc_model_svh

// floor of the mean of the four orthogonal neighbors
function automatic int orth_mean(int r, int c);
  return (img[r-1][c] + img[r+1][c] + img[r][c-1] + img[r][c+1]) / 4;
endfunction

function automatic bit static_hit(int r, int c);
  for (int k = 0; k < dpc_pkg::static_num; k++) begin
    if (st_vld[k] && (st_coord[k].row == r) && (st_coord[k].col == c)) begin
      return 1'b1;
    end
  end
  return 1'b0;
endfunction

function automatic int sat_count(int n);
  return (n > 255) ? 255 : n;
endfunction

task automatic model_frame();
  int  ctr;
  int  val;
  int  nmax;
  int  nmin;
  int  kind;                                      // 0 none, 1 white, 2 black, 3 static
  int  n_w;
  int  n_b;
  int  n_s;
  bit  interior;
  bit  st_on;
  bit  dyn_on;
  n_w    = 0;
  n_b    = 0;
  n_s    = 0;
  st_on  = (cfg_mode == dpc_pkg::mode_static) || (cfg_mode == dpc_pkg::mode_mix);
  dyn_on = (cfg_mode == dpc_pkg::mode_dynamic) || (cfg_mode == dpc_pkg::mode_mix);
  for (int r = 0; r < dpc_pkg::img_vsz; r++) begin
    for (int c = 0; c < dpc_pkg::img_hsz; c++) begin
      ctr      = img[r][c];
      val      = ctr;
      kind     = 0;
      interior = (r > 0) && (r < dpc_pkg::img_vsz - 1) && (c > 0) && (c < dpc_pkg::img_hsz - 1);
      if (interior) begin
        nmax = 0;
        nmin = (1 << dpc_pkg::pix_w) - 1;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            if ((dr != 0) || (dc != 0)) begin
              if (img[r+dr][c+dc] > nmax) nmax = img[r+dr][c+dc];
              if (img[r+dr][c+dc] < nmin) nmin = img[r+dr][c+dc];
            end
          end
        end
        if (st_on && static_hit(r, c)) begin   // static list wins in mix
          kind = 3;
          val  = orth_mean(r, c);
        end else if (dyn_on && (ctr > nmax + w_thr)) begin
          kind = 1;
          val  = nmax;
        end else if (dyn_on && (ctr + b_thr < nmin)) begin
          kind = 2;
          val  = nmin;
        end
      end
      if (cfg_debug && (kind != 0)) val = cfg_repl;
      if (kind == 1) n_w++;
      if (kind == 2) n_b++;
      if (kind == 3) n_s++;
      exp_pix.push_back(dpc_pkg::pix_t'(val));
    end
  end
  exp_w.push_back(sat_count(n_w));
  exp_b.push_back(sat_count(n_b));
  exp_s.push_back(sat_count(n_s));
endtask

`endif

// ==== bench/dpc_tb.sv ====
`timescale 1ns/100ps
// Testbench for the DPC top level. Sends six random 16x8 frames with injected
// bright and dark pixels under changing mode, thresholds and static lists,
// collects the output stream in raster order and checks each frame and its
// counts against the model at o_fend.
module dpc_tb;

  localparam int seed        = 32'h364d_4477;
  localparam int num_frames  = 6;
  localparam int frame_pix   = dpc_pkg::img_hsz * dpc_pkg::img_vsz;
  localparam int frame_len   = dpc_pkg::img_vsz * (dpc_pkg::img_hsz + 4) + dpc_pkg::img_hsz + 4;
  localparam int timeout_cyc = 2 * frame_len * num_frames;

  logic                                      clk = 1'b0;
  logic                                      rst_n;
  logic                                      i_href;
  logic                                      i_hstr;
  logic                                      i_hend;
  logic                                      i_fstr;
  dpc_pkg::pix_t                             i_data;
  dpc_pkg::mode_t                            i_mode_sel;
  logic                                      i_debug_en;
  dpc_pkg::pix_t                             i_repl_col;
  dpc_pkg::pix_t                             i_w_thres;
  dpc_pkg::pix_t                             i_b_thres;
  dpc_pkg::coord_t [dpc_pkg::static_num-1:0] i_static_coord;
  logic [dpc_pkg::static_num-1:0]            i_static_vld;
  logic                                      o_href;
  dpc_pkg::pix_t                             o_data;
  logic                                      o_hstr;
  logic                                      o_hend;
  logic                                      o_fend;
  logic [dpc_pkg::cnt_w-1:0]                 o_wdpc_cnt;
  logic [dpc_pkg::cnt_w-1:0]                 o_bdpc_cnt;
  logic [dpc_pkg::cnt_w-1:0]                 o_static_cnt;

  // ==========================================================================
  // frame under test, its configuration and the expected results
  // ==========================================================================
  int                                        img [dpc_pkg::img_vsz][dpc_pkg::img_hsz];
  dpc_pkg::mode_t                            cfg_mode;
  bit                                        cfg_debug;
  int                                        cfg_repl;
  int                                        w_thr;
  int                                        b_thr;
  dpc_pkg::coord_t [dpc_pkg::static_num-1:0] st_coord;
  logic [dpc_pkg::static_num-1:0]            st_vld;
  dpc_pkg::pix_t                             exp_pix [$];
  int                                        exp_w [$];
  int                                        exp_b [$];
  int                                        exp_s [$];
  dpc_pkg::pix_t                             got_pix [frame_pix];
  int                                        pix_idx     = 0;
  int                                        frames_seen = 0;
  int                                        err_cnt     = 0;
  int                                        chk_cnt     = 0;
  int                                        cyc_cnt     = 0;
  bit                                        seen_out    = 1'b0;
  int                                        last_w      = 0;  // published counts
  int                                        last_b      = 0;
  int                                        last_s      = 0;

  `include "dpc_model.svh"

  dpc_top dpc_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_href         (i_href),
    .i_hstr         (i_hstr),
    .i_hend         (i_hend),
    .i_fstr         (i_fstr),
    .i_data         (i_data),
    .i_mode_sel     (i_mode_sel),
    .i_debug_en     (i_debug_en),
    .i_repl_col     (i_repl_col),
    .i_w_thres      (i_w_thres),
    .i_b_thres      (i_b_thres),
    .i_static_coord (i_static_coord),
    .i_static_vld   (i_static_vld),
    .o_href         (o_href),
    .o_data         (o_data),
    .o_hstr         (o_hstr),
    .o_hend         (o_hend),
    .o_fend         (o_fend),
    .o_wdpc_cnt     (o_wdpc_cnt),
    .o_bdpc_cnt     (o_bdpc_cnt),
    .o_static_cnt   (o_static_cnt)
  );

  always #20 clk = ~clk;                          // 40 ns period

  task automatic check_val(string name, logic [31:0] got, logic [31:0] want);
    chk_cnt++;
    assert (got === want) else begin
      $display("FAIL %s: got 0x%h expected 0x%h", name, got, want);
      err_cnt++;
    end
  endtask

  // random frame around mid gray, a few hot and dark pixels, random config
  task automatic make_frame(int f);
    int r;
    int c;
    int nd;
    for (int y = 0; y < dpc_pkg::img_vsz; y++) begin
      for (int x = 0; x < dpc_pkg::img_hsz; x++) begin
        img[y][x] = 300 + $urandom_range(0, 63);
      end
    end
    nd = 4 + $urandom_range(0, 4);
    for (int d = 0; d < nd; d++) begin
      r = $urandom_range(0, dpc_pkg::img_vsz - 1);
      c = $urandom_range(0, dpc_pkg::img_hsz - 1);
      if (d == 0) begin                           // interior, also static entry 0
        r = 1 + $urandom_range(0, dpc_pkg::img_vsz - 3);
        c = 1 + $urandom_range(0, dpc_pkg::img_hsz - 3);
        st_coord[0].row = r[dpc_pkg::row_w-1:0];
        st_coord[0].col = c[dpc_pkg::col_w-1:0];
      end
      img[r][c] = (d % 2 == 0) ? $urandom_range(400, 1023) : $urandom_range(0, 300);
    end
    st_vld[0] = 1'b1;
    for (int k = 1; k < dpc_pkg::static_num; k++) begin
      r = $urandom_range(0, dpc_pkg::img_vsz - 1);
      c = $urandom_range(0, dpc_pkg::img_hsz - 1);
      st_coord[k].row = r[dpc_pkg::row_w-1:0];
      st_coord[k].col = c[dpc_pkg::col_w-1:0];
      st_vld[k]       = ($urandom_range(0, 1) == 1);
    end
    case (f)
      0:       cfg_mode = dpc_pkg::mode_off;
      1:       cfg_mode = dpc_pkg::mode_dynamic;
      2:       cfg_mode = dpc_pkg::mode_static;
      3, 4:    cfg_mode = dpc_pkg::mode_mix;
      default: cfg_mode = dpc_pkg::mode_t'($urandom_range(0, 3));
    endcase
    cfg_debug = (f == 4);
    cfg_repl  = $urandom_range(0, 1023);
    w_thr     = $urandom_range(0, 600);
    b_thr     = $urandom_range(0, 250);
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      i_href <= 1'b0;
      i_hstr <= 1'b0;
      i_hend <= 1'b0;
      i_fstr <= 1'b0;
    end
  endtask

  task automatic send_frame();
    for (int r = 0; r < dpc_pkg::img_vsz; r++) begin
      for (int c = 0; c < dpc_pkg::img_hsz; c++) begin
        @(posedge clk);
        if ((r == 0) && (c == 0)) begin           // config moves with the frame start
          i_mode_sel     <= cfg_mode;
          i_debug_en     <= cfg_debug;
          i_repl_col     <= dpc_pkg::pix_t'(cfg_repl);
          i_w_thres      <= dpc_pkg::pix_t'(w_thr);
          i_b_thres      <= dpc_pkg::pix_t'(b_thr);
          i_static_coord <= st_coord;
          i_static_vld   <= st_vld;
        end
        i_href <= 1'b1;
        i_hstr <= (c == 0);
        i_hend <= (c == dpc_pkg::img_hsz - 1);
        i_fstr <= (r == 0) && (c == 0);
        i_data <= dpc_pkg::pix_t'(img[r][c]);
      end
      // bottom row needs img_hsz+4 idle cycles to flush
      idle((r == dpc_pkg::img_vsz - 1) ? dpc_pkg::img_hsz + 4 : 2 + $urandom_range(0, 2));
    end
  endtask

  task automatic check_frame();
    dpc_pkg::pix_t want;
    chk_cnt++;
    assert (exp_pix.size() >= frame_pix) else begin
      $display("output frame %0d arrived with no expected frame to compare", frames_seen);
      err_cnt++;
    end
    if (exp_pix.size() >= frame_pix) begin
      for (int i = 0; i < frame_pix; i++) begin
        want = exp_pix.pop_front();
        check_val($sformatf("o_data[%0d][%0d] frame %0d", i / dpc_pkg::img_hsz,
                            i % dpc_pkg::img_hsz, frames_seen), got_pix[i], want);
      end
      last_w = exp_w.pop_front();
      last_b = exp_b.pop_front();
      last_s = exp_s.pop_front();
      check_val("o_wdpc_cnt", o_wdpc_cnt, last_w);
      check_val("o_bdpc_cnt", o_bdpc_cnt, last_b);
      check_val("o_static_cnt", o_static_cnt, last_s);
    end
  endtask

  // ==========================================================================
  // output collector, sampled mid-cycle
  // ==========================================================================
  always @(negedge clk) begin
    if (rst_n) begin
      if (!o_fend) begin                          // counts hold between frame ends
        check_val("o_wdpc_cnt", o_wdpc_cnt, last_w);
        check_val("o_bdpc_cnt", o_bdpc_cnt, last_b);
        check_val("o_static_cnt", o_static_cnt, last_s);
      end
      if (!o_href) begin
        check_val("o_hstr", o_hstr, 0);
        check_val("o_hend", o_hend, 0);
        check_val("o_fend", o_fend, 0);
        if (!seen_out) check_val("o_data", o_data, 0);
      end else begin
        seen_out = 1'b1;
        check_val("o_hstr", o_hstr, (pix_idx % dpc_pkg::img_hsz) == 0);
        check_val("o_hend", o_hend, (pix_idx % dpc_pkg::img_hsz) == dpc_pkg::img_hsz - 1);
        check_val("o_fend", o_fend, pix_idx == frame_pix - 1);
        if (pix_idx < frame_pix) got_pix[pix_idx] = o_data;
        pix_idx++;
        if (o_fend) begin
          check_frame();
          pix_idx = 0;
          frames_seen++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= timeout_cyc) begin
      $display("timeout after %0d cycles with %0d of %0d frames received",
               cyc_cnt, frames_seen, num_frames);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    void'($urandom(seed));
    rst_n          = 1'b0;
    i_href         = 1'b0;
    i_hstr         = 1'b0;
    i_hend         = 1'b0;
    i_fstr         = 1'b0;
    i_data         = '0;
    i_mode_sel     = dpc_pkg::mode_off;
    i_debug_en     = 1'b0;
    i_repl_col     = '0;
    i_w_thres      = '0;
    i_b_thres      = '0;
    i_static_coord = '0;
    i_static_vld   = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    idle(2);
    for (int f = 0; f < num_frames; f++) begin
      make_frame(f);
      model_frame();
      send_frame();
    end
    wait (frames_seen == num_frames);
    chk_cnt++;
    assert (exp_pix.size() == 0) else begin
      $display("%0d expected pixels were never output", exp_pix.size());
      err_cnt++;
    end
    $display("checks %0d  errors %0d  frames %0d of %0d", chk_cnt, err_cnt,
             frames_seen, num_frames);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== dpc_top.f ====
+incdir+bench
rtl/dpc_pkg.sv
rtl/dpc_window.sv
rtl/dpc_detect.sv
rtl/dpc_output_stage.sv
rtl/dpc_top.sv
bench/dpc_tb.sv

// ==== rtl/dpc_detect.sv ====
`timescale 1ns/100ps
// Execute stage of the DPC pipeline. Classifies the window center as white,
// black or static defect and picks the replacement value. Frame-edge pixels
// pass through untouched. Result is registered, one cycle latency.
module dpc_detect (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        i_win_vld,
  input  dpc_pkg::win_t                               i_win,
  input  logic [dpc_pkg::row_w-1:0]                   i_win_row,
  input  logic [dpc_pkg::col_w-1:0]                   i_win_col,
  input  dpc_pkg::mode_t                              i_mode_sel,
  input  logic                                        i_debug_en,
  input  dpc_pkg::pix_t                               i_repl_col,
  input  dpc_pkg::pix_t                               i_w_thres,
  input  dpc_pkg::pix_t                               i_b_thres,
  input  dpc_pkg::coord_t [dpc_pkg::static_num-1:0]   i_static_coord,
  input  logic [dpc_pkg::static_num-1:0]              i_static_vld,
  output logic                                        o_px_vld,
  output dpc_pkg::pix_t                               o_px_data,
  output logic [dpc_pkg::row_w-1:0]                   o_px_row,
  output logic [dpc_pkg::col_w-1:0]                   o_px_col,
  output dpc_pkg::defect_t                            o_px_defect
);

  dpc_pkg::pix_t           center;
  dpc_pkg::pix_t           nb_max;
  dpc_pkg::pix_t           nb_min;
  logic [dpc_pkg::pix_w+1:0] nb_sum;    // four orthogonal neighbors
  dpc_pkg::pix_t           nb_mean;
  logic [dpc_pkg::pix_w:0] w_lim;
  logic [dpc_pkg::pix_w:0] b_lvl;
  logic                    is_edge;
  logic                    st_en;
  logic                    dyn_en;
  logic                    st_hit;
  logic                    is_white;
  logic                    is_black;
  dpc_pkg::defect_t        defect;
  dpc_pkg::pix_t           repl;

  assign center = i_win[4];

  assign is_edge = (i_win_row == '0) || (i_win_row == dpc_pkg::last_row) ||
                   (i_win_col == '0) || (i_win_col == dpc_pkg::last_col);

  assign st_en  = (i_mode_sel == dpc_pkg::mode_static) || (i_mode_sel == dpc_pkg::mode_mix);
  assign dyn_en = (i_mode_sel == dpc_pkg::mode_dynamic) || (i_mode_sel == dpc_pkg::mode_mix);

  // ==========================================================================
  // neighborhood statistics
  // ==========================================================================
  always_comb begin
    nb_max = '0;
    nb_min = '1;
    for (int i = 0; i < 9; i++) begin
      if (i != 4) begin
        if (i_win[i] > nb_max) nb_max = i_win[i];
        if (i_win[i] < nb_min) nb_min = i_win[i];
      end
    end
  end

  assign nb_sum  = i_win[1] + i_win[3] + i_win[5] + i_win[7];
  assign nb_mean = nb_sum[dpc_pkg::pix_w+1:2];              // floor of /4

  // one extra bit so max+thres cannot wrap
  assign w_lim    = {1'b0, nb_max} + i_w_thres;
  assign b_lvl    = {1'b0, center} + i_b_thres;
  assign is_white = {1'b0, center} > w_lim;
  assign is_black = b_lvl < {1'b0, nb_min};

  // static coordinate lookup
  always_comb begin
    st_hit = 1'b0;
    for (int k = 0; k < dpc_pkg::static_num; k++) begin
      if (i_static_vld[k] && (i_static_coord[k].row == i_win_row) &&
          (i_static_coord[k].col == i_win_col)) begin
        st_hit = 1'b1;
      end
    end
  end

  // ==========================================================================
  // classification, static wins over dynamic
  // ==========================================================================
  always_comb begin
    defect = dpc_pkg::def_none;
    repl   = center;
    if (!is_edge) begin
      if (st_en && st_hit) begin
        defect = dpc_pkg::def_static;
        repl   = nb_mean;
      end else if (dyn_en && is_white) begin
        defect = dpc_pkg::def_white;
        repl   = nb_max;
      end else if (dyn_en && is_black) begin
        defect = dpc_pkg::def_black;
        repl   = nb_min;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_px_vld <= 1'b0;
    end else begin
      o_px_vld <= i_win_vld;
    end
  end

  always_ff @(posedge clk) begin
    o_px_row    <= i_win_row;
    o_px_col    <= i_win_col;
    o_px_defect <= defect;
    // debug paints every defect with the marker color
    o_px_data   <= (i_debug_en && (defect != dpc_pkg::def_none)) ? i_repl_col : repl;
  end

  // back-to-back windows always belong to one frame
  a_mode_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (i_win_vld && $past(i_win_vld)) |-> $stable(i_mode_sel));

endmodule

// ==== rtl/dpc_output_stage.sv ====
`timescale 1ns/100ps
// Result stage of the DPC pipeline. Registers the corrected pixel, rebuilds
// line and frame markers from its position and keeps per-frame defect counts.
// Counts are published together with o_fend and held until the next frame end.
module dpc_output_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_px_vld,
  input  dpc_pkg::pix_t             i_px_data,
  input  logic [dpc_pkg::row_w-1:0] i_px_row,
  input  logic [dpc_pkg::col_w-1:0] i_px_col,
  input  dpc_pkg::defect_t          i_px_defect,
  output logic                      o_href,
  output dpc_pkg::pix_t             o_data,
  output logic                      o_hstr,
  output logic                      o_hend,
  output logic                      o_fend,
  output logic [dpc_pkg::cnt_w-1:0] o_wdpc_cnt,
  output logic [dpc_pkg::cnt_w-1:0] o_bdpc_cnt,
  output logic [dpc_pkg::cnt_w-1:0] o_static_cnt
);

  logic [dpc_pkg::cnt_w-1:0] acc_w;
  logic [dpc_pkg::cnt_w-1:0] acc_b;
  logic [dpc_pkg::cnt_w-1:0] acc_s;
  logic                      is_last;

  function automatic logic [dpc_pkg::cnt_w-1:0] sat_add(
    input logic [dpc_pkg::cnt_w-1:0] cnt,
    input logic                      inc
  );
    return (inc && (cnt != '1)) ? cnt + 1'b1 : cnt;
  endfunction

  assign is_last = (i_px_row == dpc_pkg::last_row) && (i_px_col == dpc_pkg::last_col);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_href <= 1'b0;
      o_hstr <= 1'b0;
      o_hend <= 1'b0;
      o_fend <= 1'b0;
      o_data <= '0;
    end else begin
      o_href <= i_px_vld;
      o_hstr <= i_px_vld && (i_px_col == '0);
      o_hend <= i_px_vld && (i_px_col == dpc_pkg::last_col);
      o_fend <= i_px_vld && is_last;
      if (i_px_vld) begin
        o_data <= i_px_data;
      end
    end
  end

  // ==========================================================================
  // per-frame defect counters
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_w        <= '0;
      acc_b        <= '0;
      acc_s        <= '0;
      o_wdpc_cnt   <= '0;
      o_bdpc_cnt   <= '0;
      o_static_cnt <= '0;
    end else if (i_px_vld) begin
      if (is_last) begin                                  // publish and restart
        o_wdpc_cnt   <= sat_add(acc_w, i_px_defect == dpc_pkg::def_white);
        o_bdpc_cnt   <= sat_add(acc_b, i_px_defect == dpc_pkg::def_black);
        o_static_cnt <= sat_add(acc_s, i_px_defect == dpc_pkg::def_static);
        acc_w        <= '0;
        acc_b        <= '0;
        acc_s        <= '0;
      end else begin
        acc_w <= sat_add(acc_w, i_px_defect == dpc_pkg::def_white);
        acc_b <= sat_add(acc_b, i_px_defect == dpc_pkg::def_black);
        acc_s <= sat_add(acc_s, i_px_defect == dpc_pkg::def_static);
      end
    end
  end

  // a line leaves as one unbroken run, o_hend img_hsz-1 cycles after o_hstr
  a_line_run: assert property (@(posedge clk) disable iff (!rst_n)
    o_hstr |-> ##(dpc_pkg::img_hsz - 1) o_hend);

endmodule

// ==== rtl/dpc_pkg.sv ====
// Shared sizes, types and codes for the defective pixel correction block.
// Every DPC module refers to these by scoped name.
package dpc_pkg;

  // ==========================================================================
  // frame geometry
  // ==========================================================================
  localparam int pix_w      = 10;                 // raw pixel bits
  localparam int img_hsz    = 16;                 // pixels per line
  localparam int img_vsz    = 8;                  // lines per frame
  localparam int col_w      = $clog2(img_hsz);
  localparam int row_w      = $clog2(img_vsz);
  localparam int static_num = 4;                  // static coordinate slots
  localparam int cnt_w      = 8;                  // frame counters, saturate at 255

  localparam logic [col_w-1:0] last_col = col_w'(img_hsz - 1);
  localparam logic [row_w-1:0] last_row = row_w'(img_vsz - 1);

  // ==========================================================================
  // data types
  // ==========================================================================
  typedef logic [pix_w-1:0] pix_t;

  // 3x3 neighborhood in raster order, [4] is the center
  typedef pix_t [8:0] win_t;

  typedef struct packed {
    logic [row_w-1:0] row;
    logic [col_w-1:0] col;
  } coord_t;

  typedef enum logic [1:0] {
    def_none   = 2'd0,
    def_white  = 2'd1,
    def_black  = 2'd2,
    def_static = 2'd3
  } defect_t;

  typedef enum logic [1:0] {
    mode_off     = 2'd0,   // pass through
    mode_static  = 2'd1,
    mode_dynamic = 2'd2,
    mode_mix     = 2'd3    // static first, then dynamic
  } mode_t;

endpackage

// ==== rtl/dpc_top.sv ====
`timescale 1ns/100ps
// Defective pixel correction for a 16x8 monochrome raw stream, one pixel per
// clock. Chains window build, detection and output staging. Configuration
// inputs are expected to stay constant for the length of a frame.
module dpc_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        i_href,
  input  logic                                        i_hstr,
  input  logic                                        i_hend,
  input  logic                                        i_fstr,
  input  dpc_pkg::pix_t                               i_data,
  input  dpc_pkg::mode_t                              i_mode_sel,
  input  logic                                        i_debug_en,
  input  dpc_pkg::pix_t                               i_repl_col,
  input  dpc_pkg::pix_t                               i_w_thres,
  input  dpc_pkg::pix_t                               i_b_thres,
  input  dpc_pkg::coord_t [dpc_pkg::static_num-1:0]   i_static_coord,
  input  logic [dpc_pkg::static_num-1:0]              i_static_vld,
  output logic                                        o_href,
  output dpc_pkg::pix_t                               o_data,
  output logic                                        o_hstr,
  output logic                                        o_hend,
  output logic                                        o_fend,
  output logic [dpc_pkg::cnt_w-1:0]                   o_wdpc_cnt,
  output logic [dpc_pkg::cnt_w-1:0]                   o_bdpc_cnt,
  output logic [dpc_pkg::cnt_w-1:0]                   o_static_cnt
);

  logic                      win_vld;
  dpc_pkg::win_t             win;
  logic [dpc_pkg::row_w-1:0] win_row;
  logic [dpc_pkg::col_w-1:0] win_col;
  logic                      px_vld;
  dpc_pkg::pix_t             px_data;
  logic [dpc_pkg::row_w-1:0] px_row;
  logic [dpc_pkg::col_w-1:0] px_col;
  dpc_pkg::defect_t          px_defect;

  dpc_window dpc_window_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_href    (i_href),
    .i_hstr    (i_hstr),
    .i_hend    (i_hend),
    .i_fstr    (i_fstr),
    .i_data    (i_data),
    .o_win_vld (win_vld),
    .o_win     (win),
    .o_win_row (win_row),
    .o_win_col (win_col)
  );

  dpc_detect dpc_detect_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_win_vld      (win_vld),
    .i_win          (win),
    .i_win_row      (win_row),
    .i_win_col      (win_col),
    .i_mode_sel     (i_mode_sel),
    .i_debug_en     (i_debug_en),
    .i_repl_col     (i_repl_col),
    .i_w_thres      (i_w_thres),
    .i_b_thres      (i_b_thres),
    .i_static_coord (i_static_coord),
    .i_static_vld   (i_static_vld),
    .o_px_vld       (px_vld),
    .o_px_data      (px_data),
    .o_px_row       (px_row),
    .o_px_col       (px_col),
    .o_px_defect    (px_defect)
  );

  dpc_output_stage dpc_output_stage_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_px_vld     (px_vld),
    .i_px_data    (px_data),
    .i_px_row     (px_row),
    .i_px_col     (px_col),
    .i_px_defect  (px_defect),
    .o_href       (o_href),
    .o_data       (o_data),
    .o_hstr       (o_hstr),
    .o_hend       (o_hend),
    .o_fend       (o_fend),
    .o_wdpc_cnt   (o_wdpc_cnt),
    .o_bdpc_cnt   (o_bdpc_cnt),
    .o_static_cnt (o_static_cnt)
  );

endmodule

// ==== rtl/dpc_window.sv ====
`timescale 1ns/100ps
// Decode stage of the DPC pipeline. Keeps the two previous lines and slides a
// 3x3 window along the incoming line, one window per valid pixel. The last
// column of a line is issued in the idle gap after i_hend, and the bottom row
// is replayed from the line memory after the frame's last line.
module dpc_window (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_href,
  input  logic                      i_hstr,
  input  logic                      i_hend,
  input  logic                      i_fstr,
  input  dpc_pkg::pix_t             i_data,
  output logic                      o_win_vld,
  output dpc_pkg::win_t             o_win,
  output logic [dpc_pkg::row_w-1:0] o_win_row,
  output logic [dpc_pkg::col_w-1:0] o_win_col
);

  dpc_pkg::pix_t             line0 [dpc_pkg::img_hsz];  // row r-1
  dpc_pkg::pix_t             line1 [dpc_pkg::img_hsz];  // row r
  logic [dpc_pkg::col_w-1:0] col_cnt;                   // next column expected
  logic [dpc_pkg::row_w-1:0] row_cnt;                   // row of current line
  logic [dpc_pkg::col_w-1:0] in_col;
  logic [dpc_pkg::row_w-1:0] in_row;
  logic                      tail_pend;                 // trailing column due
  logic                      tail_last;                 // tail of the last line
  logic                      fl_act;                    // bottom row replay
  logic [dpc_pkg::col_w:0]   fl_cnt;
  logic [dpc_pkg::col_w-1:0] fl_col;
  logic [dpc_pkg::col_w-1:0] rd_col;
  logic                      shift_en;
  dpc_pkg::pix_t             new_top;
  dpc_pkg::pix_t             new_mid;
  dpc_pkg::pix_t             new_bot;

  // ==========================================================================
  // position of the incoming pixel
  // ==========================================================================
  assign in_col = i_hstr ? '0 : col_cnt;
  assign in_row = i_fstr ? '0 : (i_hstr ? row_cnt + 1'b1 : row_cnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (i_href) begin
      col_cnt <= in_col + 1'b1;
      row_cnt <= in_row;
    end
  end

  // line memories, row r+1 pushes row r down
  always_ff @(posedge clk) begin
    if (i_href) begin
      line0[in_col] <= line1[in_col];
      line1[in_col] <= i_data;
    end
  end

  // ==========================================================================
  // trailing column and bottom row flush
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_pend <= 1'b0;
      tail_last <= 1'b0;
      fl_act    <= 1'b0;
      fl_cnt    <= '0;
    end else begin
      tail_pend <= i_href && i_hend && (in_row != '0);   // row 0 has no window yet
      if (i_href && i_hend) begin
        tail_last <= (in_row == dpc_pkg::last_row);
      end
      if (tail_pend && tail_last) begin
        fl_act <= 1'b1;
        fl_cnt <= '0;
      end else if (fl_act) begin
        fl_cnt <= fl_cnt + 1'b1;
        if (fl_cnt == dpc_pkg::img_hsz) begin
          fl_act <= 1'b0;
        end
      end
    end
  end

  assign fl_col   = fl_cnt[dpc_pkg::col_w-1:0] - 1'b1;   // center lags the read
  assign rd_col   = fl_act ? fl_cnt[dpc_pkg::col_w-1:0] : in_col;
  assign shift_en = i_href | tail_pend | fl_act;

  // new right-hand column; below the bottom row is never looked at
  assign new_top = line0[rd_col];
  assign new_mid = line1[rd_col];
  assign new_bot = fl_act ? line1[rd_col] : i_data;

  // ==========================================================================
  // window shift and issue
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (shift_en) begin
      o_win[0] <= o_win[1];
      o_win[1] <= o_win[2];
      o_win[2] <= new_top;
      o_win[3] <= o_win[4];
      o_win[4] <= o_win[5];
      o_win[5] <= new_mid;
      o_win[6] <= o_win[7];
      o_win[7] <= o_win[8];
      o_win[8] <= new_bot;
    end
    if (fl_act) begin
      o_win_row <= dpc_pkg::last_row;
      o_win_col <= fl_col;
    end else if (tail_pend) begin
      o_win_row <= row_cnt - 1'b1;
      o_win_col <= dpc_pkg::last_col;
    end else begin
      o_win_row <= in_row - 1'b1;
      o_win_col <= in_col - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_win_vld <= 1'b0;
    end else begin
      o_win_vld <= (i_href && (in_row != '0) && (in_col != '0)) ||
                   tail_pend || (fl_act && (fl_cnt != '0));
    end
  end

  // input stays idle while the bottom row replays
  a_flush_idle: assert property (@(posedge clk) disable iff (!rst_n)
    fl_act |-> !i_href);

  // two idle cycles after every line end
  a_hend_gap: assert property (@(posedge clk) disable iff (!rst_n)
    (i_href && i_hend) |=> !i_href [*2]);

  // i_hend lands on the img_hsz-th pixel and nowhere else
  a_line_len: assert property (@(posedge clk) disable iff (!rst_n)
    i_href |-> (i_hend == (in_col == dpc_pkg::last_col)));

endmodule
